/* build.f */
design/core_pkg.sv
design/mem_req_if.sv
design/fetch_unit.sv
design/instr_decoder.sv
design/reg_file.sv
design/load_store_unit.sv
design/core_ctrl.sv
design/tiny_core.sv
verification/mem_model.sv
verification/tiny_core_tb.sv

/* design/core_ctrl.sv */
// ************************************************************
// Instruction sequencer: execute, memory, write-back, branch,
// interrupt entry and MRET for one instruction at a time
// ************************************************************
module core_ctrl (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         instr_valid_i,
  input  logic [core_pkg::XLEN-1:0]    pc_i,
  input  core_pkg::decoded_t           dec_i,
  input  logic                         illegal_i,
  output logic                         next_o,
  output logic                         redirect_o,
  output logic [core_pkg::XLEN-1:0]    redirect_pc_o,
  output logic [core_pkg::REG_AW-1:0]  rf_raddr_a_o,
  output logic [core_pkg::REG_AW-1:0]  rf_raddr_b_o,
  input  logic [core_pkg::XLEN-1:0]    rf_rdata_a_i,
  input  logic [core_pkg::XLEN-1:0]    rf_rdata_b_i,
  output logic                         rf_we_o,
  output logic [core_pkg::REG_AW-1:0]  rf_waddr_o,
  output logic [core_pkg::XLEN-1:0]    rf_wdata_o,
  mem_req_if.ctrl                      mem,
  input  logic                         irq_i,
  input  logic [core_pkg::IRQ_IDW-1:0] irq_id_i,
  output logic                         irq_ack_o,
  output logic [core_pkg::IRQ_IDW-1:0] irq_id_o
);

  typedef enum logic [2:0] {S_IDLE, S_WAIT, S_EXEC, S_MEM, S_WB, S_HALT} state_e;

  state_e                    state_q;
  state_e                    state_d;
  core_pkg::decoded_t        dec_q;
  logic [core_pkg::XLEN-1:0] pc_q;
  logic [core_pkg::XLEN-1:0] epc_q;
  logic [core_pkg::XLEN-1:0] ld_q;
  logic [core_pkg::XLEN-1:0] alu_res;
  logic                      ie_q;
  logic                      irq_take;
  logic                      is_alu;
  logic                      is_mem;

  // Interrupts are taken only between instructions
  assign irq_take = (state_q == S_IDLE) && irq_i && ie_q;
  assign next_o   = (state_q == S_WAIT);
  assign is_alu   = dec_q.op inside {core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_ADDI};
  assign is_mem   = dec_q.op inside {core_pkg::OP_LW, core_pkg::OP_SW, core_pkg::OP_SB};

  assign rf_raddr_a_o = dec_q.rs1;
  assign rf_raddr_b_o = dec_q.rs2;

  always_comb begin
    case (dec_q.op)
      core_pkg::OP_ADD: alu_res = rf_rdata_a_i + rf_rdata_b_i;
      core_pkg::OP_SUB: alu_res = rf_rdata_a_i - rf_rdata_b_i;
      default:          alu_res = rf_rdata_a_i + dec_q.imm;
    endcase
  end

  always_comb begin
    state_d       = state_q;
    redirect_o    = 1'b0;
    redirect_pc_o = core_pkg::IRQ_VECTOR;
    case (state_q)
      S_IDLE: begin
        if (irq_take) begin
          redirect_o = 1'b1;
        end else begin
          state_d = S_WAIT;
        end
      end
      S_WAIT: if (instr_valid_i) state_d = S_EXEC;
      S_EXEC: begin
        state_d = S_IDLE;
        case (dec_q.op)
          core_pkg::OP_LW, core_pkg::OP_SW, core_pkg::OP_SB: state_d = S_MEM;
          core_pkg::OP_BNE: begin
            redirect_o    = (rf_rdata_a_i != rf_rdata_b_i);
            redirect_pc_o = pc_q + (dec_q.imm << 2);
          end
          core_pkg::OP_MRET: begin
            redirect_o    = 1'b1;
            redirect_pc_o = epc_q;
          end
          core_pkg::OP_HALT: state_d = S_HALT;
          default: state_d = S_IDLE;
        endcase
      end
      S_MEM: begin
        if (mem.done) state_d = (dec_q.op == core_pkg::OP_LW) ? S_WB : S_IDLE;
      end
      S_WB: state_d = S_IDLE;
      default: state_d = state_q;
    endcase
  end

  // Write port shared by ALU results, loads and the interrupt ID
  assign rf_we_o    = irq_take || ((state_q == S_EXEC) && is_alu) || (state_q == S_WB);
  assign rf_waddr_o = irq_take ? core_pkg::IRQ_ID_REG : dec_q.rd;
  assign rf_wdata_o = irq_take ? {{(core_pkg::XLEN - core_pkg::IRQ_IDW){1'b0}}, irq_id_i} :
                      (state_q == S_WB) ? ld_q : alu_res;

  assign mem.start   = (state_q == S_EXEC) && is_mem;
  assign mem.we      = (dec_q.op != core_pkg::OP_LW);
  assign mem.is_byte = (dec_q.op == core_pkg::OP_SB);
  assign mem.addr    = alu_res;
  assign mem.wdata   = rf_rdata_b_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      ie_q      <= 1'b1;
      irq_ack_o <= 1'b0;
      irq_id_o  <= '0;
    end else begin
      state_q   <= state_d;
      irq_ack_o <= irq_take;
      if (irq_take) begin
        ie_q     <= 1'b0;
        irq_id_o <= irq_id_i;
      end else if ((state_q == S_EXEC) && (dec_q.op == core_pkg::OP_MRET)) begin
        ie_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == S_WAIT) && instr_valid_i) begin
      dec_q <= dec_i;
      pc_q  <= pc_i;
      // Unknown opcodes stop the core like HALT
      if (illegal_i) dec_q.op <= core_pkg::OP_HALT;
    end
    if (irq_take) epc_q <= pc_i;
    if (mem.done) ld_q <= mem.rdata;
  end

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    irq_ack_o |=> !irq_ack_o);

endmodule

/* design/core_pkg.sv */
// ************************************************************
// Shared widths, instruction encoding and fixed addresses of
// the multicycle core, referenced by scoped name everywhere
// ************************************************************
package core_pkg;

  localparam int unsigned XLEN    = 32;
  localparam int unsigned REG_AW  = 3;
  localparam int unsigned IRQ_IDW = 5;

  // Instruction field layout
  localparam int unsigned OP_W    = 4;
  localparam int unsigned IMM_W   = 16;
  localparam int unsigned OP_LSB  = 28;
  localparam int unsigned RD_LSB  = 25;
  localparam int unsigned RS1_LSB = 22;
  localparam int unsigned RS2_LSB = 19;

  localparam logic [XLEN-1:0]   BOOT_ADDR  = 32'h0000_0100;
  localparam logic [XLEN-1:0]   IRQ_VECTOR = 32'h0000_0800;
  // r6 receives the interrupt ID on entry
  localparam logic [REG_AW-1:0] IRQ_ID_REG = 3'd6;

  typedef enum logic [OP_W-1:0] {
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_ADDI = 4'h3,
    OP_LW   = 4'h4,
    OP_SW   = 4'h5,
    OP_SB   = 4'h6,
    OP_BNE  = 4'h7,
    OP_MRET = 4'h8,
    OP_HALT = 4'h9
  } op_e;

  typedef struct packed {
    op_e               op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   imm;
  } decoded_t;

endpackage

/* design/fetch_unit.sv */
// ************************************************************
// Program counter and instruction port handshake; one fetch
// per next request, word passed on with rvalid
// ************************************************************
module fetch_unit (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      fetch_enable_i,
  input  logic                      next_i,
  input  logic                      redirect_i,
  input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
  output logic                      instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0] instr_rdata_i,
  output logic                      instr_valid_o,
  output logic [core_pkg::XLEN-1:0] instr_o,
  output logic [core_pkg::XLEN-1:0] pc_o
);

  typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT} fstate_e;

  fstate_e                   state_q;
  logic [core_pkg::XLEN-1:0] pc_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= F_IDLE;
      pc_q    <= core_pkg::BOOT_ADDR;
    end else begin
      case (state_q)
        F_IDLE: if (next_i && fetch_enable_i) state_q <= F_REQ;
        F_REQ:  if (instr_gnt_i) state_q <= F_WAIT;
        F_WAIT: if (instr_rvalid_i) state_q <= F_IDLE;
        default: state_q <= F_IDLE;
      endcase
      // Redirect wins over sequential advance
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (instr_valid_o) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  assign instr_req_o   = (state_q == F_REQ);
  assign instr_addr_o  = pc_q;
  assign instr_valid_o = (state_q == F_WAIT) && instr_rvalid_i;
  assign instr_o       = instr_rdata_i;
  assign pc_o          = pc_q;

  // Request and address hold until the memory grants
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

/* design/instr_decoder.sv */
// ************************************************************
// Combinational split of an instruction word into fields,
// with a flag for opcodes outside the ISA
// ************************************************************
module instr_decoder (
  input  logic [core_pkg::XLEN-1:0] instr_i,
  output core_pkg::decoded_t        dec_o,
  output logic                      illegal_o
);

  logic [core_pkg::OP_W-1:0]  opcode;
  logic [core_pkg::IMM_W-1:0] imm_raw;

  assign opcode  = instr_i[core_pkg::OP_LSB +: core_pkg::OP_W];
  assign imm_raw = instr_i[core_pkg::IMM_W-1:0];

  always_comb begin
    dec_o.op  = core_pkg::op_e'(opcode);
    dec_o.rd  = instr_i[core_pkg::RD_LSB +: core_pkg::REG_AW];
    dec_o.rs1 = instr_i[core_pkg::RS1_LSB +: core_pkg::REG_AW];
    dec_o.rs2 = instr_i[core_pkg::RS2_LSB +: core_pkg::REG_AW];
    // Sign extend the 16-bit immediate
    dec_o.imm = {{(core_pkg::XLEN - core_pkg::IMM_W){imm_raw[core_pkg::IMM_W-1]}}, imm_raw};
  end

  always_comb begin
    case (opcode)
      core_pkg::OP_ADD,
      core_pkg::OP_SUB,
      core_pkg::OP_ADDI,
      core_pkg::OP_LW,
      core_pkg::OP_SW,
      core_pkg::OP_SB,
      core_pkg::OP_BNE,
      core_pkg::OP_MRET,
      core_pkg::OP_HALT: illegal_o = 1'b0;
      default:           illegal_o = 1'b1;
    endcase
  end

endmodule

/* design/load_store_unit.sv */
// ************************************************************
// Data port master: latches one request on start, holds it
// until grant and reports done with the response
// ************************************************************
module load_store_unit (
  input  logic                      clk,
  input  logic                      rst_n_i,
  mem_req_if.lsu                    req,
  output logic                      data_req_o,
  output logic                      data_we_o,
  output logic [3:0]                data_be_o,
  output logic [core_pkg::XLEN-1:0] data_addr_o,
  output logic [core_pkg::XLEN-1:0] data_wdata_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic [core_pkg::XLEN-1:0] data_rdata_i
);

  typedef enum logic [1:0] {L_IDLE, L_REQ, L_WAIT} lstate_e;

  lstate_e                   state_q;
  logic                      we_q;
  logic [3:0]                be_q;
  logic [core_pkg::XLEN-1:0] addr_q;
  logic [core_pkg::XLEN-1:0] wdata_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= L_IDLE;
    end else begin
      case (state_q)
        L_IDLE: if (req.start) state_q <= L_REQ;
        L_REQ:  if (data_gnt_i) state_q <= L_WAIT;
        L_WAIT: if (data_rvalid_i) state_q <= L_IDLE;
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // Request payload, captured once per access
  always_ff @(posedge clk) begin
    if (req.start) begin
      we_q   <= req.we;
      addr_q <= {req.addr[core_pkg::XLEN-1:2], 2'b00};
      if (req.is_byte) begin
        be_q    <= 4'b0001 << req.addr[1:0];
        wdata_q <= {4{req.wdata[7:0]}};
      end else begin
        be_q    <= 4'b1111;
        wdata_q <= req.wdata;
      end
    end
  end

  assign data_req_o   = (state_q == L_REQ);
  assign data_we_o    = we_q;
  assign data_be_o    = be_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign req.done  = (state_q == L_WAIT) && data_rvalid_i;
  assign req.rdata = data_rdata_i;

  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    req.start |-> state_q == L_IDLE);

  // A response needs a granted request still open
  a_rvalid_granted: assert property (@(posedge clk) disable iff (!rst_n_i)
    data_rvalid_i |-> state_q == L_WAIT);

endmodule

/* design/mem_req_if.sv */
// ************************************************************
// One data request from the control unit to the load-store
// unit, with a start and done pulse pair
// ************************************************************
interface mem_req_if;

  logic                      start;
  logic                      we;
  logic                      is_byte;
  logic [core_pkg::XLEN-1:0] addr;
  logic [core_pkg::XLEN-1:0] wdata;
  logic                      done;
  logic [core_pkg::XLEN-1:0] rdata;

  modport ctrl (output start, we, is_byte, addr, wdata, input done, rdata);

  modport lsu (input start, we, is_byte, addr, wdata, output done, rdata);

endinterface

/* design/reg_file.sv */
// ************************************************************
// Eight 32-bit registers, two read ports and one write port;
// r0 is fixed at zero
// ************************************************************
module reg_file (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [core_pkg::REG_AW-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]   rdata_a_o,
  output logic [core_pkg::XLEN-1:0]   rdata_b_o,
  input  logic                        we_i,
  input  logic [core_pkg::REG_AW-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]   wdata_i
);

  logic [core_pkg::XLEN-1:0] regs_q [2**core_pkg::REG_AW];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 2**core_pkg::REG_AW; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* design/tiny_core.sv */
// ************************************************************
// Top level of the multicycle core; instruction, data and
// interrupt signals leave as plain ports
// ************************************************************
module tiny_core (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         fetch_enable_i,
  output logic                         instr_req_o,
  output logic [core_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                         instr_gnt_i,
  input  logic                         instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]    instr_rdata_i,
  output logic                         data_req_o,
  output logic                         data_we_o,
  output logic [3:0]                   data_be_o,
  output logic [core_pkg::XLEN-1:0]    data_addr_o,
  output logic [core_pkg::XLEN-1:0]    data_wdata_o,
  input  logic                         data_gnt_i,
  input  logic                         data_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]    data_rdata_i,
  input  logic                         irq_i,
  input  logic [core_pkg::IRQ_IDW-1:0] irq_id_i,
  output logic                         irq_ack_o,
  output logic [core_pkg::IRQ_IDW-1:0] irq_id_o
);

  logic                        next;
  logic                        redirect;
  logic [core_pkg::XLEN-1:0]   redirect_pc;
  logic                        instr_valid;
  logic [core_pkg::XLEN-1:0]   instr;
  logic [core_pkg::XLEN-1:0]   pc;
  core_pkg::decoded_t          dec;
  logic                        illegal;
  logic [core_pkg::REG_AW-1:0] raddr_a;
  logic [core_pkg::REG_AW-1:0] raddr_b;
  logic [core_pkg::XLEN-1:0]   rdata_a;
  logic [core_pkg::XLEN-1:0]   rdata_b;
  logic                        rf_we;
  logic [core_pkg::REG_AW-1:0] rf_waddr;
  logic [core_pkg::XLEN-1:0]   rf_wdata;

  mem_req_if mem_req ();

  fetch_unit fetch_unit_inst (
    .clk(clk), .rst_n_i(rst_n_i), .fetch_enable_i(fetch_enable_i),
    .next_i(next), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o), .instr_gnt_i(instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i), .instr_rdata_i(instr_rdata_i),
    .instr_valid_o(instr_valid), .instr_o(instr), .pc_o(pc)
  );

  instr_decoder instr_decoder_inst (.instr_i(instr), .dec_o(dec), .illegal_o(illegal));

  reg_file reg_file_inst (
    .clk(clk), .rst_n_i(rst_n_i), .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
    .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

  load_store_unit load_store_unit_inst (
    .clk(clk), .rst_n_i(rst_n_i), .req(mem_req.lsu),
    .data_req_o(data_req_o), .data_we_o(data_we_o), .data_be_o(data_be_o),
    .data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o), .data_gnt_i(data_gnt_i),
    .data_rvalid_i(data_rvalid_i), .data_rdata_i(data_rdata_i)
  );

  core_ctrl core_ctrl_inst (
    .clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid), .pc_i(pc),
    .dec_i(dec), .illegal_i(illegal), .next_o(next),
    .redirect_o(redirect), .redirect_pc_o(redirect_pc),
    .rf_raddr_a_o(raddr_a), .rf_raddr_b_o(raddr_b),
    .rf_rdata_a_i(rdata_a), .rf_rdata_b_i(rdata_b),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .mem(mem_req.ctrl), .irq_i(irq_i), .irq_id_i(irq_id_i),
    .irq_ack_o(irq_ack_o), .irq_id_o(irq_id_o)
  );

endmodule

/* verification/mem_model.sv */
// ************************************************************
// Memory responder for one request/grant/rvalid port, with
// random grant and response delays of 0 to 3 cycles
// ************************************************************
module mem_model #(
  parameter logic [31:0] SEED = 32'd97233
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Word array, indexed by address bits 11 to 2
  logic [31:0] mem [1024];
  logic [31:0] lcg_q = SEED;
  logic [9:0]  idx;
  logic        busy = 1'b0;
  int          gnt_wait = 0;
  int          rsp_wait = 0;

  function int next_delay();
    lcg_q = lcg_q * 32'd1103515245 + 32'd12345;
    return int'(lcg_q[17:16]);
  endfunction

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
  end

  // Outputs change on the falling edge only
  always @(negedge clk) begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    if (!rst_n_i) begin
      busy     = 1'b0;
      gnt_wait = next_delay();
    end else if (busy) begin
      if (rsp_wait == 0) begin
        rvalid_o = 1'b1;
        rdata_o  = mem[idx];
        busy     = 1'b0;
        gnt_wait = next_delay();
      end else begin
        rsp_wait--;
      end
    end else if (req_i) begin
      if (gnt_wait == 0) begin
        gnt_o = 1'b1;
        idx   = addr_i[11:2];
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) mem[idx][8*b +: 8] = wdata_i[8*b +: 8];
          end
        end
        busy     = 1'b1;
        rsp_wait = next_delay();
      end else begin
        gnt_wait--;
      end
    end
  end

endmodule

/* verification/tiny_core_tb.sv */
// ************************************************************
// Self-checking testbench of the core that runs four programs
// and compares stores, memory and interrupt IDs with an ISA model
// ************************************************************
module tiny_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] DATA_BASE = 32'h0000_0400;
  localparam logic [31:0] LOG_BASE  = 32'h0000_0600;
  localparam logic [31:0] DONE_ADDR = 32'h0000_07F0;
  localparam int          BOOT_IDX  = core_pkg::BOOT_ADDR >> 2;
  localparam int          VEC_IDX   = core_pkg::IRQ_VECTOR >> 2;

  logic                         clk;
  logic                         rst_n_i;
  logic                         fetch_enable_i;
  logic                         instr_req_o;
  logic [core_pkg::XLEN-1:0]    instr_addr_o;
  logic                         instr_gnt;
  logic                         instr_rvalid;
  logic [core_pkg::XLEN-1:0]    instr_rdata;
  logic                         data_req_o;
  logic                         data_we_o;
  logic [3:0]                   data_be_o;
  logic [core_pkg::XLEN-1:0]    data_addr_o;
  logic [core_pkg::XLEN-1:0]    data_wdata_o;
  logic                         data_gnt;
  logic                         data_rvalid;
  logic [core_pkg::XLEN-1:0]    data_rdata;
  logic                         irq_i;
  logic [core_pkg::IRQ_IDW-1:0] irq_id_i;
  logic                         irq_ack_o;
  logic [core_pkg::IRQ_IDW-1:0] irq_id_o;

  logic [31:0]                  prog [$];
  logic [31:0]                  exp_addr [$];
  logic [3:0]                   exp_be [$];
  logic [31:0]                  exp_data [$];
  logic [31:0]                  ref_mem [logic [31:0]];
  logic [core_pkg::IRQ_IDW-1:0] raised_ids [$];
  logic [core_pkg::IRQ_IDW-1:0] ack_ids [$];
  logic [31:0]                  log_words [$];
  logic [31:0]                  tb_lcg = 32'd97233;
  int                           errors = 0;
  int                           cycles = 0;
  int                           deadline = 1000000;
  int                           wr_idx;
  bit                           done_seen;
  bit                           first_fetch;
  bit                           ack_prev;

  always #4 clk = ~clk;

  tiny_core tiny_core_inst (
    .clk(clk), .rst_n_i(rst_n_i), .fetch_enable_i(fetch_enable_i),
    .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o), .instr_gnt_i(instr_gnt),
    .instr_rvalid_i(instr_rvalid), .instr_rdata_i(instr_rdata),
    .data_req_o(data_req_o), .data_we_o(data_we_o), .data_be_o(data_be_o),
    .data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o), .data_gnt_i(data_gnt),
    .data_rvalid_i(data_rvalid), .data_rdata_i(data_rdata),
    .irq_i(irq_i), .irq_id_i(irq_id_i), .irq_ack_o(irq_ack_o), .irq_id_o(irq_id_o)
  );

  mem_model imem_inst (
    .clk(clk), .rst_n_i(rst_n_i), .req_i(instr_req_o), .we_i(1'b0), .be_i(4'b0000),
    .addr_i(instr_addr_o), .wdata_i(32'h0), .gnt_o(instr_gnt),
    .rvalid_o(instr_rvalid), .rdata_o(instr_rdata)
  );

  mem_model dmem_inst (
    .clk(clk), .rst_n_i(rst_n_i), .req_i(data_req_o), .we_i(data_we_o), .be_i(data_be_o),
    .addr_i(data_addr_o), .wdata_i(data_wdata_o), .gnt_o(data_gnt),
    .rvalid_o(data_rvalid), .rdata_o(data_rdata)
  );

  function automatic logic [31:0] enc(core_pkg::op_e op, int rd, int rs1, int rs2, int imm);
    return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000, imm[15:0]};
  endfunction

  // Initial data memory word that differs at every address
  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
  endfunction

  function logic [31:0] next_rand();
    tb_lcg = tb_lcg * 32'd1103515245 + 32'd12345;
    return tb_lcg;
  endfunction

  function automatic logic [31:0] read_ref(logic [31:0] addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
  endfunction

  // ISA model of the main program that counts executed instructions
  function automatic int run_reference();
    logic [31:0] regs [8];
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] w;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] word;
    logic [3:0]  op;
    int          rd;
    int          rs1;
    int          rs2;
    int          idx;
    int          steps;
    foreach (regs[i]) regs[i] = '0;
    exp_addr.delete();
    exp_be.delete();
    exp_data.delete();
    ref_mem.delete();
    pc = core_pkg::BOOT_ADDR;
    steps = 0;
    while (steps < 4000) begin
      idx = int'((pc - core_pkg::BOOT_ADDR) >> 2);
      w = (idx < prog.size()) ? prog[idx] : 32'h0;
      steps++;
      op = w[31:28];
      rd = w[27:25];
      rs1 = w[24:22];
      rs2 = w[21:19];
      imm = {{16{w[15]}}, w[15:0]};
      a = regs[rs1] + imm;
      pc_next = pc + 32'd4;
      case (op)
        core_pkg::OP_ADD:  regs[rd] = regs[rs1] + regs[rs2];
        core_pkg::OP_SUB:  regs[rd] = regs[rs1] - regs[rs2];
        core_pkg::OP_ADDI: regs[rd] = a;
        core_pkg::OP_LW:   regs[rd] = read_ref({a[31:2], 2'b00});
        core_pkg::OP_SW: begin
          ref_mem[{a[31:2], 2'b00}] = regs[rs2];
          exp_addr.push_back({a[31:2], 2'b00});
          exp_be.push_back(4'hF);
          exp_data.push_back(regs[rs2]);
        end
        core_pkg::OP_SB: begin
          word = read_ref({a[31:2], 2'b00});
          word[8*a[1:0] +: 8] = regs[rs2][7:0];
          ref_mem[{a[31:2], 2'b00}] = word;
          exp_addr.push_back({a[31:2], 2'b00});
          exp_be.push_back(4'b0001 << a[1:0]);
          exp_data.push_back({4{regs[rs2][7:0]}});
        end
        core_pkg::OP_BNE: if (regs[rs1] != regs[rs2]) pc_next = pc + (imm << 2);
        default: return steps;
      endcase
      regs[0] = '0;
      pc = pc_next;
    end
    return steps;
  endfunction

  task automatic compare_word(string what, logic [core_pkg::XLEN-1:0] got,
                              logic [core_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_be(logic [3:0] got, logic [3:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: byte enables got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic compare_id(logic [core_pkg::IRQ_IDW-1:0] got,
                            logic [core_pkg::IRQ_IDW-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: interrupt ID got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic check_idle();
    if (instr_req_o !== 1'b0 || data_req_o !== 1'b0 || irq_ack_o !== 1'b0) begin
      errors++;
      $display("A request or acknowledge was active before fetch was enabled at %0t", $time);
    end
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= deadline) begin
      errors++;
      $display("Timeout at %0t: the program did not reach its done store", $time);
      finish_run();
    end
  end

  // Observes every data write and every acknowledge
  always @(posedge clk) begin
    if (rst_n_i) begin
      if (first_fetch && instr_req_o) begin
        compare_word("first fetch address", instr_addr_o, core_pkg::BOOT_ADDR);
        first_fetch = 1'b0;
      end
      if (irq_ack_o) begin
        if (ack_prev) begin
          errors++;
          $display("irq_ack_o stayed high for more than one cycle at %0t", $time);
        end
        ack_ids.push_back(irq_id_o);
      end
      ack_prev = irq_ack_o;
      if (data_req_o && data_gnt && data_we_o) begin
        if (data_addr_o >= LOG_BASE && data_addr_o < LOG_BASE + 32'h100) begin
          log_words.push_back(data_wdata_o);
        end else if (wr_idx >= exp_addr.size()) begin
          errors++;
          $display("Store to %h at %0t was not predicted by the model", data_addr_o, $time);
        end else begin
          compare_word("store address", data_addr_o, exp_addr[wr_idx]);
          compare_be(data_be_o, exp_be[wr_idx]);
          compare_word("store data", data_wdata_o, exp_data[wr_idx]);
          wr_idx++;
        end
        if (data_addr_o == DONE_ADDR) done_seen = 1'b1;
      end
    end
  end

  task automatic raise_irqs();
    logic [31:0] r;
    for (int k = 0; k < 3; k++) begin
      r = next_rand();
      repeat (30 + int'(r[3:0])) @(negedge clk);
      r = next_rand();
      irq_id_i = r[core_pkg::IRQ_IDW-1:0];
      irq_i = 1'b1;
      raised_ids.push_back(irq_id_i);
      @(negedge clk);
      while (!irq_ack_o) @(negedge clk);
      irq_i = 1'b0;
    end
  endtask

  task automatic run_test(bit with_irq);
    int count;
    rst_n_i = 1'b0;
    fetch_enable_i = 1'b0;
    irq_i = 1'b0;
    irq_id_i = '0;
    count = run_reference();
    deadline = cycles + 40 * count + 200;
    for (int i = 0; i < 1024; i++) begin
      imem_inst.mem[i] = 32'h0;
      dmem_inst.mem[i] = fill_word(i << 2);
    end
    foreach (prog[i]) imem_inst.mem[BOOT_IDX + i] = prog[i];
    // Handler logs r6 through the r7 pointer
    imem_inst.mem[VEC_IDX]     = enc(core_pkg::OP_SW, 0, 7, 6, 0);
    imem_inst.mem[VEC_IDX + 1] = enc(core_pkg::OP_ADDI, 7, 7, 0, 4);
    imem_inst.mem[VEC_IDX + 2] = enc(core_pkg::OP_MRET, 0, 0, 0, 0);
    wr_idx = 0;
    done_seen = 1'b0;
    first_fetch = 1'b1;
    ack_prev = 1'b0;
    raised_ids.delete();
    ack_ids.delete();
    log_words.delete();
    repeat (4) @(negedge clk) check_idle();
    rst_n_i = 1'b1;
    repeat (3) @(negedge clk) check_idle();
    fetch_enable_i = 1'b1;
    if (with_irq) raise_irqs();
    while (!done_seen) @(negedge clk);
    repeat (10) @(negedge clk);
    if (wr_idx != exp_addr.size()) begin
      errors++;
      $display("Only %0d of %0d predicted stores were seen", wr_idx, exp_addr.size());
    end
    foreach (ref_mem[a]) compare_word("final memory", dmem_inst.mem[a[11:2]], ref_mem[a]);
    if (with_irq) begin
      if (ack_ids.size() != 3 || log_words.size() != 3) begin
        errors++;
        $display("Expected 3 acknowledges and 3 log stores, saw %0d and %0d",
                 ack_ids.size(), log_words.size());
      end else begin
        for (int k = 0; k < 3; k++) begin
          compare_id(ack_ids[k], raised_ids[k]);
          compare_word("logged ID", log_words[k], {27'b0, raised_ids[k]});
        end
      end
    end
  endtask

  task automatic add_done();
    prog.push_back(enc(core_pkg::OP_SW, 0, 0, 1, int'(DONE_ADDR)));
    prog.push_back(enc(core_pkg::OP_HALT, 0, 0, 0, 0));
  endtask

  initial begin
    clk = 1'b0;
    rst_n_i = 1'b0;
    fetch_enable_i = 1'b0;
    irq_i = 1'b0;
    irq_id_i = '0;
    // Arithmetic with r0 writes dropped
    prog = '{enc(core_pkg::OP_ADDI, 1, 0, 0, 100), enc(core_pkg::OP_ADDI, 2, 0, 0, -7),
             enc(core_pkg::OP_ADD, 3, 1, 2, 0), enc(core_pkg::OP_SUB, 4, 2, 1, 0),
             enc(core_pkg::OP_ADDI, 0, 1, 0, 5), enc(core_pkg::OP_ADD, 5, 0, 1, 0),
             enc(core_pkg::OP_ADDI, 7, 0, 0, int'(DATA_BASE)),
             enc(core_pkg::OP_SW, 0, 7, 3, 0), enc(core_pkg::OP_SW, 0, 7, 4, 4),
             enc(core_pkg::OP_SW, 0, 7, 5, 8), enc(core_pkg::OP_SW, 0, 7, 0, 12)};
    add_done();
    run_test(1'b0);
    // Loads, stores and all four byte lanes
    prog = '{enc(core_pkg::OP_ADDI, 1, 0, 0, 16'h1234), enc(core_pkg::OP_ADDI, 2, 0, 0, 'h400),
             enc(core_pkg::OP_SW, 0, 2, 1, 0), enc(core_pkg::OP_LW, 3, 2, 0, 0),
             enc(core_pkg::OP_ADDI, 3, 3, 0, 1), enc(core_pkg::OP_SW, 0, 2, 3, 4),
             enc(core_pkg::OP_SB, 0, 2, 1, 8), enc(core_pkg::OP_SB, 0, 2, 3, 9),
             enc(core_pkg::OP_SB, 0, 2, 1, 10), enc(core_pkg::OP_SB, 0, 2, 3, 11),
             enc(core_pkg::OP_LW, 4, 2, 0, 8), enc(core_pkg::OP_SW, 0, 2, 4, 12),
             enc(core_pkg::OP_LW, 5, 2, 0, 4), enc(core_pkg::OP_SW, 0, 2, 5, 16)};
    add_done();
    run_test(1'b0);
    // Countdown loop
    prog = '{enc(core_pkg::OP_ADDI, 1, 0, 0, 5), enc(core_pkg::OP_ADDI, 2, 0, 0, 'h400),
             enc(core_pkg::OP_SW, 0, 2, 1, 0), enc(core_pkg::OP_ADDI, 2, 2, 0, 4),
             enc(core_pkg::OP_ADDI, 1, 1, 0, -1), enc(core_pkg::OP_BNE, 0, 1, 0, -3)};
    add_done();
    run_test(1'b0);
    // Long loop interrupted three times
    prog = '{enc(core_pkg::OP_ADDI, 7, 0, 0, int'(LOG_BASE)),
             enc(core_pkg::OP_ADDI, 1, 0, 0, 25), enc(core_pkg::OP_ADDI, 2, 0, 0, 'h480),
             enc(core_pkg::OP_SW, 0, 2, 1, 0), enc(core_pkg::OP_ADDI, 2, 2, 0, 4),
             enc(core_pkg::OP_ADDI, 1, 1, 0, -1), enc(core_pkg::OP_BNE, 0, 1, 0, -3)};
    add_done();
    run_test(1'b1);
    finish_run();
  end

endmodule
